//--- source/ex_isa_pkg.sv
/*
 * Execute stage ISA constants
 * Word width, functional-unit select bits, micro-op codes and the
 * multiplier step count shared by the execute stage units.
 */
`default_nettype none

package ex_isa_pkg;

    localparam int XLEN      = 32;              // Data word width
    localparam int SHAMT_W   = 5;               // Shift amount bits
    localparam int MUL_STEPS = 32;              // One step per multiplier bit
    localparam int MUL_CW    = 6;               // Must hold MUL_STEPS

    typedef logic [XLEN-1:0] word_t;            // One data word
    typedef logic [3:0]      fu_t;              // One-hot unit select
    typedef logic [4:0]      uop_t;             // Micro-op code

    // Bit positions inside fu_t
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;

    //--------------------------------------------------
    // Micro-ops, meaning depends on the selected unit
    //--------------------------------------------------
    localparam uop_t ALU_ADD  = 5'd0;
    localparam uop_t ALU_SUB  = 5'd1;
    localparam uop_t ALU_AND  = 5'd2;
    localparam uop_t ALU_OR   = 5'd3;
    localparam uop_t ALU_XOR  = 5'd4;
    localparam uop_t ALU_SLL  = 5'd5;
    localparam uop_t ALU_SRL  = 5'd6;
    localparam uop_t ALU_SRA  = 5'd7;
    localparam uop_t ALU_SLT  = 5'd8;
    localparam uop_t ALU_SLTU = 5'd9;

    localparam uop_t MUL_MUL   = 5'd0;          // Low product word
    localparam uop_t MUL_MULHU = 5'd1;          // High product word

    localparam uop_t LSU_LOAD  = 5'd0;
    localparam uop_t LSU_STORE = 5'd1;

    // Conditional branches sit in 5'b00xxx
    localparam uop_t CFU_BEQ       = 5'b00_000;
    localparam uop_t CFU_BNE       = 5'b00_001;
    localparam uop_t CFU_BLT       = 5'b00_010;
    localparam uop_t CFU_BGE       = 5'b00_011;
    localparam uop_t CFU_BLTU      = 5'b00_100;
    localparam uop_t CFU_BGEU      = 5'b00_101;
    localparam uop_t CFU_JAL       = 5'b10_000;
    localparam uop_t CFU_JALR      = 5'b10_001;
    localparam uop_t CFU_TAKEN     = 5'b11_000; // Resolved branch outcomes
    localparam uop_t CFU_NOT_TAKEN = 5'b11_001;

endpackage

`default_nettype wire

//--- source/ex_pipe_pkg.sv
/*
 * Execute stage pipeline bundles
 * Stage input, stage-3 control and operand payloads, and the
 * forwarding bundle seen by the decode stage.
 */
`default_nettype none

package ex_pipe_pkg;

    // Everything the upstream stage hands over
    typedef struct packed {
        logic [4:0]        rd;                  // Destination register
        ex_isa_pkg::fu_t   fu;                  // Functional unit
        ex_isa_pkg::uop_t  uop;                 // Micro-op code
        ex_isa_pkg::word_t opr_a;               // Operand A
        ex_isa_pkg::word_t opr_b;               // Operand B
        ex_isa_pkg::word_t opr_c;               // Store data / jal target
        logic              trap;                // Raise a trap
        logic [31:0]       instr;               // Instruction word
    } ex_in_t;

    //--------------------------------------------------
    // Stage-3 payloads
    //--------------------------------------------------
    typedef struct packed {
        logic              valid;               // Entry holds an instruction
        logic [4:0]        rd;
        ex_isa_pkg::fu_t   fu;
        ex_isa_pkg::uop_t  uop;                 // Resolved for branches
        logic              trap;
        logic [31:0]       instr;
    } ex_ctrl_t;

    typedef struct packed {
        ex_isa_pkg::word_t opr_a;               // Result or address
        ex_isa_pkg::word_t opr_b;               // Store data or trap cause
    } ex_opr_t;

    // Bypass view of the instruction still in stage 2
    typedef struct packed {
        logic [4:0]        rd;
        ex_isa_pkg::word_t wdata;               // Value to bypass
        logic              load;                // Data not known yet
    } ex_fwd_t;

endpackage

`default_nettype wire

//--- source/ex_alu.sv
/*
 * Integer ALU
 * Add, subtract, logic, shifts and set-less-than, plus compare flags
 * for branches and the raw adder sum for address generation.
 */
`default_nettype none

module ex_alu (
    input  wire ex_isa_pkg::uop_t  i_uop,       // Operation select
    input  wire ex_isa_pkg::word_t i_lhs,       // Left operand
    input  wire ex_isa_pkg::word_t i_rhs,       // Right operand
    input  wire logic              i_unsigned,  // Unsigned compare
    output ex_isa_pkg::word_t      o_result,    // Selected ALU result
    output ex_isa_pkg::word_t      o_sum,       // lhs + rhs
    output logic                   o_lt,        // lhs < rhs
    output logic                   o_eq         // lhs == rhs
);

    import ex_isa_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = i_rhs[SHAMT_W-1:0];          // Low bits only, as in RV32I
    assign o_sum = i_lhs + i_rhs;
    assign o_eq  = i_lhs == i_rhs;

    // One comparator serves slt/sltu and all branch conditions
    assign o_lt  = i_unsigned ? (i_lhs < i_rhs) :
                                ($signed(i_lhs) < $signed(i_rhs));

    //--------------------------------------------------
    // Result select
    //--------------------------------------------------
    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = o_sum;
            ALU_SUB:  o_result = i_lhs - i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_SLL:  o_result = i_lhs << shamt;
            ALU_SRL:  o_result = i_lhs >> shamt;
            ALU_SRA:  o_result = $signed(i_lhs) >>> shamt; // Sign fill
            ALU_SLT,
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt}; // i_unsigned picks
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/ex_mul_iter.sv
/*
 * Iterative unsigned multiplier
 * One shift-add step per cycle, MUL_STEPS steps per product.
 * The full 64-bit product is held until the next start.
 */
`default_nettype none

module ex_mul_iter (
    input  wire logic              g_clk,
    input  wire logic              g_resetn,
    input  wire logic              i_start,     // Load operands, begin
    input  wire logic              i_flush,     // Abort current product
    input  wire ex_isa_pkg::word_t i_a,         // Multiplicand
    input  wire ex_isa_pkg::word_t i_b,         // Multiplier
    output logic                   o_done,      // Product valid
    output logic [2*ex_isa_pkg::XLEN-1:0] o_result
);

    import ex_isa_pkg::*;

    logic [MUL_CW-1:0]   count;                 // Steps still to go
    logic [2*XLEN-1:0]   prod;                  // {partial sum, multiplier}
    word_t               mcand;                 // Held multiplicand
    logic [XLEN:0]       step_sum;              // Carry out kept

    // Add multiplicand into the high half when the low bit is set
    assign step_sum = {1'b0, prod[2*XLEN-1:XLEN]} +
                      (prod[0] ? {1'b0, mcand} : {(XLEN+1){1'b0}});

    //--------------------------------------------------
    // Step counter and done flag
    //--------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            count  <= '0;
            o_done <= 1'b0;
        end else if (i_start) begin
            count  <= MUL_CW'(MUL_STEPS);       // Count down to zero
            o_done <= 1'b0;
        end else if (count != '0) begin
            count  <= count - 1'b1;
            o_done <= count == MUL_CW'(1);      // Last step this edge
        end
    end

    // Datapath, no reset needed
    always_ff @(posedge g_clk) begin
        if (i_start) begin
            prod  <= {{XLEN{1'b0}}, i_b};
            mcand <= i_a;
        end else if (count != '0) begin
            prod  <= {step_sum, prod[XLEN-1:1]}; // Shift right one
        end
    end

    assign o_result = prod;

    // The controller must not restart a product that is still running
    a_no_restart: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_start |-> count == '0);

endmodule

`default_nettype wire

//--- source/ex_stall_fsm.sv
/*
 * Execute stage stall control
 * Issues single-cycle instructions directly and holds stage 2 busy
 * while a multiply runs or waits for stage 3 to drain.
 */
`default_nettype none

module ex_stall_fsm (
    input  wire logic g_clk,
    input  wire logic g_resetn,
    input  wire logic i_s2_valid,               // Upstream presents an op
    input  wire logic i_is_mul,                 // That op needs the multiplier
    input  wire logic i_mul_done,               // Product ready
    input  wire logic i_s3_valid,               // Stage 3 occupied
    input  wire logic i_s3_busy,                // Stage 3 stalled downstream
    input  wire logic i_flush,
    output logic      o_s2_busy,
    output logic      o_issue,                  // Write a valid entry to stage 3
    output logic      o_advance,                // Stage 3 may be overwritten
    output logic      o_mul_start               // First cycle of MUL_RUN
);

    typedef enum logic [1:0] {IDLE, MUL_RUN, MUL_WAIT} state_t;

    state_t state;
    logic   mul_fin;                            // Multiply result available

    assign o_advance = !i_s3_valid || !i_s3_busy;

    // Done is stale in the start cycle, it still shows the last product
    assign mul_fin = (state == MUL_RUN && i_mul_done && !o_mul_start) ||
                     state == MUL_WAIT;

    assign o_issue = o_advance &&
                     ((state == IDLE && i_s2_valid && !i_is_mul) || mul_fin);

    // Idle without a multiply only stalls on stage 3
    assign o_s2_busy = (state != IDLE || i_is_mul) ? !o_issue : !o_advance;

    //--------------------------------------------------
    // State register
    //--------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            state       <= IDLE;
            o_mul_start <= 1'b0;
        end else begin
            o_mul_start <= 1'b0;
            case (state)
                IDLE: if (i_s2_valid && i_is_mul) begin
                    state       <= MUL_RUN;
                    o_mul_start <= 1'b1;        // One pulse per multiply
                end
                MUL_RUN: if (mul_fin) begin
                    state <= o_advance ? IDLE : MUL_WAIT;
                end
                MUL_WAIT: if (o_advance) begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Upstream holds a multiply until it issues
    a_mul_held: assert property (@(posedge g_clk) disable iff (!g_resetn || i_flush)
        (state != IDLE) |-> (i_s2_valid && i_is_mul));
    // A new start clears the last product's done flag
    a_done_clr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_mul_start |=> !i_mul_done);

endmodule

`default_nettype wire

//--- source/ex_stage_reg.sv
/*
 * Pipeline register
 * Loadable and flushable, payload type given by parameter.
 */
`default_nettype none

module ex_stage_reg #(
    parameter type T = logic                    // Payload struct
) (
    input  wire logic g_clk,
    input  wire logic g_resetn,
    input  wire logic i_load,                   // Capture i_data
    input  wire logic i_flush,                  // Clear to zero
    input  wire T     i_data,
    output T          o_data
);

    // Flush wins over load
    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_data <= '0;
        end else if (i_load) begin
            o_data <= i_data;
        end
    end

endmodule

`default_nettype wire

//--- source/ex_stage.sv
/*
 * RISC-V execute stage
 * Decodes the unit select, drives ALU, multiplier and branch logic,
 * and writes results into the stage-3 pipeline registers.
 */
`default_nettype none

module ex_stage (
    input  wire logic               g_clk,
    input  wire logic               g_resetn,
    input  wire ex_pipe_pkg::ex_in_t i_s2,      // Instruction from decode
    input  wire logic               i_s2_valid,
    input  wire logic               i_flush,
    input  wire logic               i_s3_busy,  // Memory stage stalled
    output logic                    o_s2_busy,
    output ex_pipe_pkg::ex_ctrl_t   o_s3,
    output ex_pipe_pkg::ex_opr_t    o_s3_opr,
    output ex_pipe_pkg::ex_fwd_t    o_fwd
);

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic fu_alu, fu_mul, fu_lsu, fu_cfu;
    logic alu_unsigned, alu_lt, alu_eq;
    logic cfu_cond, cfu_taken, lsu_store;
    logic issue, advance, mul_start, mul_done;
    word_t alu_result, alu_sum, opr_a_cfu, opr_a_mul;
    logic [2*XLEN-1:0] mul_result;
    ex_ctrl_t n_ctrl;
    ex_opr_t  n_opr;

    assign fu_alu = i_s2.fu[FU_ALU];
    assign fu_mul = i_s2.fu[FU_MUL];
    assign fu_lsu = i_s2.fu[FU_LSU];
    assign fu_cfu = i_s2.fu[FU_CFU];

    //--------------------------------------------------
    // Branch compare
    //--------------------------------------------------
    assign cfu_cond     = fu_cfu && i_s2.uop[4:3] == 2'b00;
    assign alu_unsigned = (fu_alu && i_s2.uop == ALU_SLTU) ||
                          (fu_cfu && (i_s2.uop == CFU_BLTU || i_s2.uop == CFU_BGEU));

    always_comb begin
        case (i_s2.uop)
            CFU_BEQ:          cfu_taken = alu_eq;
            CFU_BNE:          cfu_taken = !alu_eq;
            CFU_BLT, CFU_BLTU: cfu_taken = alu_lt; // Sign set by alu_unsigned
            CFU_BGE, CFU_BGEU: cfu_taken = !alu_lt;
            default:          cfu_taken = 1'b0;
        endcase
    end

    // Jump targets are halfword aligned
    assign opr_a_cfu = (i_s2.uop == CFU_JALR) ? {alu_sum[XLEN-1:1], 1'b0} :
                                                {i_s2.opr_c[XLEN-1:1], 1'b0};
    assign opr_a_mul = (i_s2.uop == MUL_MULHU) ? mul_result[2*XLEN-1:XLEN] :
                                                 mul_result[XLEN-1:0];
    assign lsu_store = fu_lsu && i_s2.uop == LSU_STORE;

    //--------------------------------------------------
    // Next stage-3 contents
    //--------------------------------------------------
    always_comb begin
        n_ctrl.valid = issue;
        n_ctrl.rd    = i_s2.rd;
        n_ctrl.fu    = i_s2.fu;
        n_ctrl.uop   = cfu_cond ? (cfu_taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_s2.uop;
        n_ctrl.trap  = i_s2.trap;
        n_ctrl.instr = i_s2.instr;
        n_opr.opr_a  = ({XLEN{fu_alu}} & alu_result) |
                       ({XLEN{fu_mul}} & opr_a_mul)  |
                       ({XLEN{fu_lsu}} & alu_sum)    | // Load/store address
                       ({XLEN{fu_cfu}} & opr_a_cfu);
        if (i_s2.trap) begin
            n_opr.opr_b = {{(XLEN-5){1'b0}}, i_s2.rd}; // Trap cause
        end else begin
            n_opr.opr_b = lsu_store ? i_s2.opr_c : '0;
        end
    end

    assign o_fwd.rd    = i_s2.rd;
    assign o_fwd.wdata = n_opr.opr_a;
    assign o_fwd.load  = i_s2_valid && fu_lsu && i_s2.uop == LSU_LOAD;

    ex_alu u_alu (
        .i_uop      (i_s2.uop),
        .i_lhs      (i_s2.opr_a),
        .i_rhs      (i_s2.opr_b),
        .i_unsigned (alu_unsigned),
        .o_result   (alu_result),
        .o_sum      (alu_sum),
        .o_lt       (alu_lt),
        .o_eq       (alu_eq)
    );

    ex_mul_iter u_mul (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_start  (mul_start),
        .i_flush  (i_flush),
        .i_a      (i_s2.opr_a),
        .i_b      (i_s2.opr_b),
        .o_done   (mul_done),
        .o_result (mul_result)
    );

    ex_stall_fsm u_fsm (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_s2_valid  (i_s2_valid),
        .i_is_mul    (fu_mul),
        .i_mul_done  (mul_done),
        .i_s3_valid  (o_s3.valid),
        .i_s3_busy   (i_s3_busy),
        .i_flush     (i_flush),
        .o_s2_busy   (o_s2_busy),
        .o_issue     (issue),
        .o_advance   (advance),
        .o_mul_start (mul_start)
    );

    ex_stage_reg #(.T(ex_ctrl_t)) u_ctrl_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (advance),                    // Bubble when nothing issues
        .i_flush  (i_flush),
        .i_data   (n_ctrl),
        .o_data   (o_s3)
    );

    ex_stage_reg #(.T(ex_opr_t)) u_opr_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (issue),
        .i_flush  (i_flush),
        .i_data   (n_opr),
        .o_data   (o_s3_opr)
    );

    // A stalled stage-3 entry must not change under the memory stage
    a_s3_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_s3.valid && i_s3_busy && !i_flush) |=> ($stable(o_s3) && $stable(o_s3_opr)));

endmodule

`default_nettype wire

//--- test/ex_checker.sv
/*
 * Execute stage checker
 * Records accepted instructions, predicts the stage-3 payload from the
 * ISA rules and compares it when stage 3 hands the result on.
 */
`default_nettype none

module ex_checker #(
    parameter int NAME_W = 96                   // Test name, 8 bits a character
) (
    input  wire logic                  g_clk,
    input  wire logic                  g_resetn,
    input  wire ex_pipe_pkg::ex_in_t   i_s2,
    input  wire logic                  i_s2_valid,
    input  wire logic                  i_flush,
    input  wire logic                  i_s3_busy,
    input  wire logic                  i_s2_busy,   // DUT stage 2 busy
    input  wire ex_pipe_pkg::ex_ctrl_t i_s3,
    input  wire ex_pipe_pkg::ex_opr_t  i_s3_opr,
    input  wire ex_pipe_pkg::ex_fwd_t  i_fwd,
    input  wire logic [NAME_W-1:0]     i_name,
    output int                         o_tests,
    output int                         o_errors,
    output int                         o_pending    // Accepted, not yet seen
);

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    ex_ctrl_t          ctrl_q[$];               // Expected, in issue order
    ex_opr_t           opr_q[$];
    logic [NAME_W-1:0] name_q[$];
    logic              rst_d;
    logic              flush_d;                 // Flush seen on last edge
    logic [NAME_W-1:0] flush_name;

    function automatic string name_str(input logic [NAME_W-1:0] v);
        string s;
        s = "";
        for (int i = NAME_W/8-1; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, v[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic logic branch_taken(input ex_in_t ins);
        case (ins.uop)
            CFU_BEQ:  return ins.opr_a == ins.opr_b;
            CFU_BNE:  return ins.opr_a != ins.opr_b;
            CFU_BLT:  return $signed(ins.opr_a) < $signed(ins.opr_b);
            CFU_BGE:  return $signed(ins.opr_a) >= $signed(ins.opr_b);
            CFU_BLTU: return ins.opr_a < ins.opr_b;
            CFU_BGEU: return ins.opr_a >= ins.opr_b;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic ex_ctrl_t expect_ctrl(input ex_in_t ins);
        ex_ctrl_t e;
        e.valid = 1'b1;
        e.rd    = ins.rd;
        e.fu    = ins.fu;
        e.uop   = ins.uop;
        e.trap  = ins.trap;
        e.instr = ins.instr;
        if (ins.fu[FU_CFU] && ins.uop inside {CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,
                                              CFU_BLTU, CFU_BGEU}) begin
            e.uop = branch_taken(ins) ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
        return e;
    endfunction

    function automatic ex_opr_t expect_opr(input ex_in_t ins);
        ex_opr_t        e;
        logic [2*XLEN-1:0] prod;
        e    = '0;
        prod = {{XLEN{1'b0}}, ins.opr_a} * {{XLEN{1'b0}}, ins.opr_b};
        if (ins.fu[FU_ALU]) begin
            case (ins.uop)
                ALU_ADD:  e.opr_a = ins.opr_a + ins.opr_b;
                ALU_SUB:  e.opr_a = ins.opr_a - ins.opr_b;
                ALU_AND:  e.opr_a = ins.opr_a & ins.opr_b;
                ALU_OR:   e.opr_a = ins.opr_a | ins.opr_b;
                ALU_XOR:  e.opr_a = ins.opr_a ^ ins.opr_b;
                ALU_SLL:  e.opr_a = ins.opr_a << ins.opr_b[4:0];
                ALU_SRL:  e.opr_a = ins.opr_a >> ins.opr_b[4:0];
                ALU_SRA:  e.opr_a = $signed(ins.opr_a) >>> ins.opr_b[4:0];
                ALU_SLT:  e.opr_a = word_t'($signed(ins.opr_a) < $signed(ins.opr_b));
                ALU_SLTU: e.opr_a = word_t'(ins.opr_a < ins.opr_b);
                default:  e.opr_a = '0;
            endcase
        end else if (ins.fu[FU_MUL]) begin
            e.opr_a = (ins.uop == MUL_MULHU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end else if (ins.fu[FU_LSU]) begin
            e.opr_a = ins.opr_a + ins.opr_b;   // Effective address
            if (ins.uop == LSU_STORE) begin
                e.opr_b = ins.opr_c;
            end
        end else if (ins.fu[FU_CFU]) begin
            // Targets lose bit 0
            e.opr_a = ((ins.uop == CFU_JALR) ? ins.opr_a + ins.opr_b : ins.opr_c) & ~32'h1;
        end
        if (ins.trap) begin
            e.opr_b = word_t'(ins.rd);          // Cause is the rd field
        end
        return e;
    endfunction

    //--------------------------------------------------
    // Monitor
    //--------------------------------------------------
    always @(posedge g_clk) begin
        ex_ctrl_t          exp_ctrl;
        ex_opr_t           exp_opr;
        logic [NAME_W-1:0] nm;
        logic              exp_load;
        if (!g_resetn) begin
            o_tests  = 0;
            o_errors = 0;
            ctrl_q.delete();
            opr_q.delete();
            name_q.delete();
            rst_d    = 1'b0;
            flush_d  = 1'b0;
        end else begin
            if (!rst_d && (i_s3.valid || i_s2_busy)) begin
                o_errors++;
                $display("error: stage 3 valid or stage 2 busy right after reset");
            end
            rst_d = 1'b1;

            if (flush_d) begin                  // Stage 3 must be empty now
                o_tests++;
                if (i_s3.valid) begin
                    o_errors++;
                    $display("error: %s left a valid stage 3 entry after flush",
                             name_str(flush_name));
                end else begin
                    $display("ok   %s", name_str(flush_name));
                end
            end
            flush_d    = i_flush;
            flush_name = i_name;

            exp_load = i_s2.fu[FU_LSU] && i_s2.uop == LSU_LOAD;
            if (i_s2_valid && i_fwd.load != exp_load) begin
                o_errors++;
                $display("mismatch %s fwd.load expected %b actual %b", name_str(i_name),
                         exp_load, i_fwd.load);
            end

            if (i_s3.valid && !i_s3_busy) begin // Consumed this edge
                if (ctrl_q.size() == 0) begin
                    o_errors++;
                    $display("error: stage 3 handed on a result that was never accepted");
                end else begin
                    exp_ctrl = ctrl_q.pop_front();
                    exp_opr  = opr_q.pop_front();
                    nm       = name_q.pop_front();
                    o_tests++;
                    if (exp_ctrl != i_s3 || exp_opr != i_s3_opr) begin
                        o_errors++;
                        $display("mismatch %s expected %h %h actual %h %h", name_str(nm),
                                 exp_ctrl, exp_opr, i_s3, i_s3_opr);
                    end else begin
                        $display("ok   %s", name_str(nm));
                    end
                end
            end

            if (i_s2_valid && !i_s2_busy) begin // Accepted this edge
                exp_opr = expect_opr(i_s2);
                // Bypass shows the result while the op is still in stage 2
                if (i_fwd.rd != i_s2.rd || i_fwd.wdata != exp_opr.opr_a) begin
                    o_errors++;
                    $display("mismatch %s fwd expected %h %h actual %h %h", name_str(i_name),
                             i_s2.rd, exp_opr.opr_a, i_fwd.rd, i_fwd.wdata);
                end
                ctrl_q.push_back(expect_ctrl(i_s2));
                opr_q.push_back(exp_opr);
                name_q.push_back(i_name);
            end

            // Entries in flight die with the flush
            if (i_flush) begin
                ctrl_q.delete();
                opr_q.delete();
                name_q.delete();
            end
            o_pending = int'(ctrl_q.size());
        end
    end

endmodule

`default_nettype wire

//--- test/tb_ex_stage.sv
/*
 * Execute stage testbench
 * Runs a table of instructions through the stage under back-pressure,
 * flushes a running multiply and reports the final counts.
 */
`default_nettype none

module tb_ex_stage;

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_STALL    = 7;            // Largest stall in the table
    localparam int NAME_W       = 96;           // Up to 12 characters

    typedef struct packed {
        logic [NAME_W-1:0] name;
        ex_in_t            ins;
        logic [3:0]        stall;               // Cycles stage 3 stays busy
        logic              flush;               // Kill the op while in stage 2
    } row_t;

    logic              g_clk = 1'b0;
    logic              g_resetn;
    ex_in_t            i_s2;
    logic              i_s2_valid;
    logic              i_flush;
    logic              i_s3_busy;
    logic              o_s2_busy;
    ex_ctrl_t          o_s3;
    ex_opr_t           o_s3_opr;
    ex_fwd_t           o_fwd;

    logic [NAME_W-1:0] cur_name;                // Row now in stage 2
    logic [3:0]        stall_req;
    int                stall_left;
    int                seed;
    int                tests;
    int                errors;
    int                pending;
    row_t              rows[$];

    always #(PERIOD/2) g_clk = !g_clk;

    ex_stage u_dut (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2       (i_s2),
        .i_s2_valid (i_s2_valid),
        .i_flush    (i_flush),
        .i_s3_busy  (i_s3_busy),
        .o_s2_busy  (o_s2_busy),
        .o_s3       (o_s3),
        .o_s3_opr   (o_s3_opr),
        .o_fwd      (o_fwd)
    );

    ex_checker #(.NAME_W(NAME_W)) u_chk (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2       (i_s2),
        .i_s2_valid (i_s2_valid),
        .i_flush    (i_flush),
        .i_s3_busy  (i_s3_busy),
        .i_s2_busy  (o_s2_busy),
        .i_s3       (o_s3),
        .i_s3_opr   (o_s3_opr),
        .i_fwd      (o_fwd),
        .i_name     (cur_name),
        .o_tests    (tests),
        .o_errors   (errors),
        .o_pending  (pending)
    );

    //--------------------------------------------------
    // Table helpers
    //--------------------------------------------------
    task automatic add_row(input logic [NAME_W-1:0] name, input int unit, input uop_t uop,
                           input word_t a, input word_t b, input word_t c, input int rd,
                           input int stall, input bit trap, input bit flush);
        row_t r;
        r           = '0;
        r.name      = name;
        r.ins.fu    = fu_t'(1 << unit);         // One-hot unit select
        r.ins.uop   = uop;
        r.ins.opr_a = a;
        r.ins.opr_b = b;
        r.ins.opr_c = c;
        r.ins.rd    = rd[4:0];
        r.ins.trap  = trap;
        r.ins.instr = {25'(rows.size()), 7'h33}; // Row number tags the word
        r.stall     = stall[3:0];
        r.flush     = flush;
        rows.push_back(r);
    endtask

    // Present one row and hold it until accepted or flushed
    task automatic apply_row(input row_t row);
        int waited;
        waited     = 0;
        i_s2       = row.ins;
        cur_name   = row.name;
        stall_req  = row.stall;
        i_s2_valid = 1'b1;
        if (row.flush) begin
            // Multiply under way and stage 3 still holding the stalled row
            do begin
                @(posedge g_clk);
                waited++;
            end while (waited < 5 || !o_s3.valid);
            #2;
            i_s2_valid = 1'b0;
            i_flush    = 1'b1;
            @(posedge g_clk);
            #2;
            i_flush    = 1'b0;
        end else begin
            do begin
                @(posedge g_clk);
            end while (o_s2_busy);              // Taken when busy is low
            #2;
        end
    endtask

    //--------------------------------------------------
    // Back-pressure, stage 3 held per row's stall count
    //--------------------------------------------------
    initial begin
        i_s3_busy  = 1'b0;
        stall_left = 0;
        forever begin
            @(posedge g_clk);
            if (i_s2_valid && !o_s2_busy) begin
                stall_left = int'(stall_req);   // Stall applies to this row
            end
            #2;
            i_s3_busy = stall_left != 0;
            if (stall_left != 0) begin
                stall_left--;
            end
        end
    end

    initial begin
        seed       = 32'hb011_ba40;
        g_resetn   = 1'b0;
        i_s2       = '0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        cur_name   = '0;
        stall_req  = '0;

        // Name, unit, uop, opr_a, opr_b, opr_c, rd, stall, trap, flush
        add_row("alu_add",  FU_ALU, ALU_ADD,  32'hf000_0f35, 32'h0000_0124, 0, 1, 0, 0, 0);
        add_row("alu_sub",  FU_ALU, ALU_SUB,  32'hf000_0f35, 32'h0000_0124, 0, 2, 3, 0, 0);
        add_row("alu_and",  FU_ALU, ALU_AND,  32'hf000_0f35, 32'h0000_0124, 0, 3, 0, 0, 0);
        add_row("alu_or",   FU_ALU, ALU_OR,   32'hf000_0f35, 32'h0000_0124, 0, 4, 1, 0, 0);
        add_row("alu_xor",  FU_ALU, ALU_XOR,  32'hf000_0f35, 32'h0000_0124, 0, 5, 7, 0, 0);
        add_row("alu_sll",  FU_ALU, ALU_SLL,  32'hf000_0f35, 32'h0000_0124, 0, 6, 0, 0, 0);
        add_row("alu_srl",  FU_ALU, ALU_SRL,  32'hf000_0f35, 32'h0000_0124, 0, 7, 2, 0, 0);
        add_row("alu_sra",  FU_ALU, ALU_SRA,  32'hf000_0f35, 32'h0000_0124, 0, 8, 0, 0, 0);
        add_row("alu_slt",  FU_ALU, ALU_SLT,  32'hf000_0f35, 32'h0000_0124, 0, 9, 0, 0, 0);
        add_row("alu_sltu", FU_ALU, ALU_SLTU, 32'hf000_0f35, 32'h0000_0124, 0, 10, 5, 0, 0);
        add_row("beq",      FU_CFU, CFU_BEQ,  32'h0000_1234, 32'h0000_1234, 32'h801, 0, 0, 0, 0);
        add_row("bne",      FU_CFU, CFU_BNE,  32'h0000_1234, 32'h0000_1234, 32'h801, 0, 2, 0, 0);
        add_row("blt",      FU_CFU, CFU_BLT,  32'hffff_fffb, 32'h0000_0003, 32'h901, 0, 0, 0, 0);
        add_row("bge",      FU_CFU, CFU_BGE,  32'hffff_fffb, 32'h0000_0003, 32'h901, 0, 0, 0, 0);
        add_row("bltu",     FU_CFU, CFU_BLTU, 32'hffff_fffb, 32'h0000_0003, 32'ha01, 0, 4, 0, 0);
        add_row("bgeu",     FU_CFU, CFU_BGEU, 32'hffff_fffb, 32'h0000_0003, 32'ha01, 0, 0, 0, 0);
        add_row("jal",      FU_CFU, CFU_JAL,  32'h0000_0000, 32'h0000_0000, 32'h4003, 1, 0, 0, 0);
        add_row("jalr",     FU_CFU, CFU_JALR, 32'h0000_1001, 32'h0000_0010, 0, 1, 1, 0, 0);
        add_row("load",     FU_LSU, LSU_LOAD, 32'h2000_0000, 32'h0000_0010, 0, 12, 4, 0, 0);
        add_row("store",    FU_LSU, LSU_STORE, 32'h2000_0100, 32'hffff_fffc,
                32'hdead_beef, 0, 0, 0, 0);
        add_row("mul_lo",   FU_MUL, MUL_MUL,   $random(seed), $random(seed), 0, 13, 0, 0, 0);
        add_row("mul_hi",   FU_MUL, MUL_MULHU, $random(seed), $random(seed), 0, 14, 6, 0, 0);
        add_row("trap",     FU_ALU, ALU_ADD,   32'h0000_0007, 32'h0000_0009, 0, 11, 2, 1, 0);
        // Still stalled in stage 3 when the next multiply is flushed
        add_row("add_flushed", FU_ALU, ALU_ADD, 32'h0000_0055, 32'h0000_00aa, 0, 18, 7, 0, 0);
        add_row("mul_flush", FU_MUL, MUL_MULHU, $random(seed), $random(seed), 0, 15, 0, 0, 1);
        add_row("mul_again", FU_MUL, MUL_MULHU, $random(seed), $random(seed), 0, 16, 3, 0, 0);
        add_row("add_tail", FU_ALU, ALU_ADD,  32'h7fff_ffff, 32'h0000_0001, 0, 17, 0, 0, 0);

        repeat (RESET_CYCLES) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;
        foreach (rows[r]) begin
            apply_row(rows[r]);
        end
        i_s2_valid = 1'b0;

        // Drain what is still in flight
        while (pending != 0) begin
            @(posedge g_clk);
            #1;
        end
        repeat (4) @(posedge g_clk);
        #1;
        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        longint limit;
        #1;
        limit = longint'(rows.size() * (MUL_STEPS + MAX_STALL + 4) + RESET_CYCLES) * PERIOD;
        #(limit);
        $display("watchdog expired after %0d time units, %0d results outstanding",
                 limit, pending);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/ex_isa_pkg.sv
source/ex_pipe_pkg.sv
source/ex_alu.sv
source/ex_mul_iter.sv
source/ex_stall_fsm.sv
source/ex_stage_reg.sv
source/ex_stage.sv
test/ex_checker.sv
test/tb_ex_stage.sv

//--- Makefile
TOP = tb_ex_stage

.PHONY: sim clean

# Build and run; the run passes only if the pass line appears in its output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
